/* source/fetch_config.svh */
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// address and cache geometry
//////////////////////////////////////////////////////////////////////

// pc width, also the apb address width
`define FETCH_ADDR_WIDTH 32

// number of 8-byte lines, power of two
`define ICACHE_LINES 16

//////////////////////////////////////////////////////////////////////
// thread start addresses
//////////////////////////////////////////////////////////////////////

`define T1_RESET_PC 32'h0000_1000
`define T2_RESET_PC 32'h0000_2000

`endif

/* source/fetch_pkg.sv */
package fetch_pkg;

	// request from the fetch stage to the icache
	typedef enum logic {
		BUS_NONE,
		BUS_LOAD
	} bus_command_e;

	// hardware thread currently selected for fetch
	typedef enum logic {
		THREAD1,
		THREAD2
	} thread_e;

	// icache line fill, two apb reads per line
	typedef enum logic [2:0] {
		FILL_IDLE,
		FILL_SETUP_LO,   // low word setup phase
		FILL_ACCESS_LO,
		FILL_SETUP_HI,   // high word setup phase
		FILL_ACCESS_HI
	} fill_state_e;

endpackage

/* source/icache_if.sv */
`timescale 1ns/10ps
`include "fetch_config.svh"

// fetch stage <-> icache lookup path
interface icache_if import fetch_pkg::*; ();

	logic [`FETCH_ADDR_WIDTH-1:0]  addr;     // group address, 8-byte aligned
	bus_command_e                  command;  // registered in the fetch stage
	logic [63:0]                   data;     // whole group, low word at addr
	logic                          hit;      // data valid this cycle

	modport fetch (
		output addr,
		output command,
		input  data,
		input  hit
	);

	modport cache (
		input  addr,
		input  command,
		output data,
		output hit
	);

endinterface

/* source/fetch_stage.sv */
`timescale 1ns/10ps
`include "fetch_config.svh"

module fetch_stage import fetch_pkg::*; (
	input  logic                          clock,
	input  logic                          reset_reg,
	input  logic                          thread1_mispredict,
	input  logic                          thread2_mispredict,
	input  logic [`FETCH_ADDR_WIDTH-1:0]  thread1_target_pc,
	input  logic [`FETCH_ADDR_WIDTH-1:0]  thread2_target_pc,
	input  logic                          rs_stall,
	input  logic                          rob1_stall,
	input  logic                          rob2_stall,
	input  logic                          rat_stall,   // free list empty
	input  logic                          thread1_halt,
	input  logic                          thread2_halt,
	icache_if.fetch                       cache,
	output logic [31:0]                   inst1_out,
	output logic [31:0]                   inst2_out,
	output logic                          inst1_valid,
	output logic                          inst2_valid,
	output thread_e                       thread_out
);

	localparam logic [`FETCH_ADDR_WIDTH-1:0] WORD_BYTES  = 4;
	localparam logic [`FETCH_ADDR_WIDTH-1:0] GROUP_BYTES = 8;

	logic [`FETCH_ADDR_WIDTH-1:0]  thread1_pc;
	logic [`FETCH_ADDR_WIDTH-1:0]  thread2_pc;
	logic [`FETCH_ADDR_WIDTH-1:0]  thread1_next_pc;
	logic [`FETCH_ADDR_WIDTH-1:0]  thread2_next_pc;
	logic [`FETCH_ADDR_WIDTH-1:0]  cur_pc;
	logic [`FETCH_ADDR_WIDTH-1:0]  pc_step;
	thread_e                       cur_thread;
	thread_e                       next_thread;
	logic                          thread1_halted;
	logic                          thread2_halted;
	logic                          next_thread1_halted;
	logic                          next_thread2_halted;
	logic                          any_stall;
	logic                          cur_mispredict;
	logic                          cur_blocked;
	logic                          deliver;
	bus_command_e                  next_command;

	//////////////////////////////////////////////////////////////////////
	// current thread view
	//////////////////////////////////////////////////////////////////////

	assign any_stall = rs_stall || rob1_stall || rob2_stall || rat_stall;

	assign cur_pc = (cur_thread == THREAD1) ? thread1_pc : thread2_pc;
	assign cur_mispredict = (cur_thread == THREAD1) ? thread1_mispredict : thread2_mispredict;
	// a thread being halted delivers nothing more
	assign cur_blocked = (cur_thread == THREAD1) ? (thread1_halt || thread1_halted)
		: (thread2_halt || thread2_halted);

	assign cache.addr = {cur_pc[`FETCH_ADDR_WIDTH-1:3], 3'b000};

	// wrong-path group is dropped when its own thread mispredicts
	assign deliver = cache.hit && !any_stall && !cur_mispredict && !cur_blocked;
	assign pc_step = cur_pc[2] ? WORD_BYTES : GROUP_BYTES;

	// upper word only when the pc sits on bit 2
	assign inst1_out   = cur_pc[2] ? cache.data[63:32] : cache.data[31:0];
	assign inst2_out   = cache.data[63:32];
	assign inst1_valid = deliver;
	assign inst2_valid = deliver && !cur_pc[2];
	assign thread_out  = cur_thread;

	assign next_command = any_stall ? BUS_NONE : BUS_LOAD;

	//////////////////////////////////////////////////////////////////////
	// halt flags, next pcs, thread selection
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		next_thread1_halted = thread1_halted;
		next_thread2_halted = thread2_halted;
		if (thread1_mispredict)
			next_thread1_halted = 1'b0;   // restart
		else if (thread1_halt)
			next_thread1_halted = 1'b1;
		if (thread2_mispredict)
			next_thread2_halted = 1'b0;
		else if (thread2_halt)
			next_thread2_halted = 1'b1;
	end

	always_comb
	begin
		thread1_next_pc = thread1_pc;
		thread2_next_pc = thread2_pc;
		if (thread1_mispredict)
			thread1_next_pc = thread1_target_pc + WORD_BYTES;
		else if (deliver && cur_thread == THREAD1)
			thread1_next_pc = thread1_pc + pc_step;
		if (thread2_mispredict)
			thread2_next_pc = thread2_target_pc + WORD_BYTES;
		else if (deliver && cur_thread == THREAD2)
			thread2_next_pc = thread2_pc + pc_step;
	end

	always_comb
	begin
		next_thread = cur_thread;
		if (!any_stall)
		begin
			if (deliver)
				next_thread = (cur_thread == THREAD1) ? THREAD2 : THREAD1;
			// never park on a halted thread while the other can run
			case (next_thread)
				THREAD1:
				begin
					if (next_thread1_halted && !next_thread2_halted)
						next_thread = THREAD2;
				end
				THREAD2:
				begin
					if (next_thread2_halted && !next_thread1_halted)
						next_thread = THREAD1;
				end
				default:
					next_thread = THREAD1;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset_reg)
		begin
			thread1_pc     <= `T1_RESET_PC;
			thread2_pc     <= `T2_RESET_PC;
			cur_thread     <= THREAD1;   // thread1 goes first
			thread1_halted <= 1'b0;
			thread2_halted <= 1'b0;
			cache.command  <= BUS_NONE;
		end
		else
		begin
			thread1_pc     <= thread1_next_pc;
			thread2_pc     <= thread2_next_pc;
			cur_thread     <= next_thread;
			thread1_halted <= next_thread1_halted;
			thread2_halted <= next_thread2_halted;
			cache.command  <= next_command;
		end
	end

	// group address holds while the cache misses
	miss_addr_held: assert property (@(posedge clock) disable iff (reset_reg)
		cache.command == BUS_LOAD && !cache.hit && !cur_blocked
		&& !thread1_mispredict && !thread2_mispredict |=> $stable(cache.addr));

endmodule

/* source/icache.sv */
`timescale 1ns/10ps
`include "fetch_config.svh"

module icache import fetch_pkg::*; (
	input  logic                          clock,
	input  logic                          reset_reg,
	input  logic [31:0]                   prdata,
	input  logic                          pready,
	icache_if.cache                       fetch,
	output logic [`FETCH_ADDR_WIDTH-1:0]  paddr,
	output logic                          psel,
	output logic                          penable,
	output logic                          pwrite
);

	localparam int INDEX_BITS = $clog2(`ICACHE_LINES);
	localparam int TAG_BITS   = `FETCH_ADDR_WIDTH - INDEX_BITS - 3;

	logic [63:0]                  data_array [`ICACHE_LINES];
	logic [TAG_BITS-1:0]          tag_array  [`ICACHE_LINES];
	logic [`ICACHE_LINES-1:0]     line_valid;

	logic [INDEX_BITS-1:0]        req_index;
	logic [TAG_BITS-1:0]          req_tag;

	fill_state_e                  fill_state;
	fill_state_e                  fill_next;
	logic [`FETCH_ADDR_WIDTH-4:0] fill_line;   // line address being filled
	logic [INDEX_BITS-1:0]        fill_index;
	logic [TAG_BITS-1:0]          fill_tag;
	logic [31:0]                  fill_lo;     // low word held until the high read
	logic                         fill_start;
	logic                         fill_done;
	logic                         fill_hi_word;

	//////////////////////////////////////////////////////////////////////
	// lookup
	//////////////////////////////////////////////////////////////////////

	assign req_index = fetch.addr[INDEX_BITS+2:3];
	assign req_tag   = fetch.addr[`FETCH_ADDR_WIDTH-1:INDEX_BITS+3];

	assign fetch.hit = (fetch.command == BUS_LOAD) && line_valid[req_index]
		&& (tag_array[req_index] == req_tag);
	assign fetch.data = data_array[req_index];

	//////////////////////////////////////////////////////////////////////
	// line fill over apb
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		fill_next = fill_state;
		case (fill_state)
			FILL_IDLE:
			begin
				if (fetch.command == BUS_LOAD && !fetch.hit)
					fill_next = FILL_SETUP_LO;
			end
			FILL_SETUP_LO:
				fill_next = FILL_ACCESS_LO;
			FILL_ACCESS_LO:
			begin
				if (pready)
					fill_next = FILL_SETUP_HI;
			end
			FILL_SETUP_HI:
				fill_next = FILL_ACCESS_HI;
			FILL_ACCESS_HI:
			begin
				if (pready)
					fill_next = FILL_IDLE;
			end
			default:
				fill_next = FILL_IDLE;
		endcase
	end

	assign fill_start   = (fill_state == FILL_IDLE) && (fill_next == FILL_SETUP_LO);
	assign fill_done    = (fill_state == FILL_ACCESS_HI) && pready;
	assign fill_hi_word = (fill_state == FILL_SETUP_HI) || (fill_state == FILL_ACCESS_HI);
	assign fill_index   = fill_line[INDEX_BITS-1:0];
	assign fill_tag     = fill_line[`FETCH_ADDR_WIDTH-4:INDEX_BITS];

	assign psel    = (fill_state != FILL_IDLE);
	assign penable = (fill_state == FILL_ACCESS_LO) || (fill_state == FILL_ACCESS_HI);
	assign paddr   = {fill_line, fill_hi_word, 2'b00};
	assign pwrite  = 1'b0;   // read only

	always_ff @(posedge clock)
	begin
		if (reset_reg)
		begin
			fill_state <= FILL_IDLE;
			line_valid <= '0;
		end
		else
		begin
			fill_state <= fill_next;
			if (fill_done)
				line_valid[fill_index] <= 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (fill_start)
			fill_line <= fetch.addr[`FETCH_ADDR_WIDTH-1:3];   // fetch may move on mid fill
		if (fill_state == FILL_ACCESS_LO && pready)
			fill_lo <= prdata;
		if (fill_done)
		begin
			data_array[fill_index] <= {prdata, fill_lo};
			tag_array[fill_index]  <= fill_tag;
		end
	end

	// apb protocol on the master side
	// access phase only with psel, and only after a setup cycle
	apb_enable_in_select: assert property (@(posedge clock) disable iff (reset_reg)
		penable |-> psel && $past(psel) && !$past(penable && pready));

	apb_addr_held: assert property (@(posedge clock) disable iff (reset_reg)
		psel && !(penable && pready) |=> $stable(paddr));

endmodule

/* source/fetch_top.sv */
`timescale 1ns/10ps
`include "fetch_config.svh"

module fetch_top import fetch_pkg::*; (
	input  logic                          clock,
	input  logic                          reset_reg,
	input  logic                          thread1_mispredict,
	input  logic                          thread2_mispredict,
	input  logic [`FETCH_ADDR_WIDTH-1:0]  thread1_target_pc,
	input  logic [`FETCH_ADDR_WIDTH-1:0]  thread2_target_pc,
	input  logic                          rs_stall,
	input  logic                          rob1_stall,
	input  logic                          rob2_stall,
	input  logic                          rat_stall,
	input  logic                          thread1_halt,
	input  logic                          thread2_halt,
	output logic [31:0]                   inst1_out,
	output logic [31:0]                   inst2_out,
	output logic                          inst1_valid,
	output logic                          inst2_valid,
	output thread_e                       thread_out,
	// apb master to instruction memory
	output logic [`FETCH_ADDR_WIDTH-1:0]  paddr,
	output logic                          psel,
	output logic                          penable,
	output logic                          pwrite,
	input  logic [31:0]                   prdata,
	input  logic                          pready
);

	icache_if icache_bus ();

	fetch_stage u_fetch_stage (
		.clock              (clock),
		.reset_reg          (reset_reg),
		.thread1_mispredict (thread1_mispredict),
		.thread2_mispredict (thread2_mispredict),
		.thread1_target_pc  (thread1_target_pc),
		.thread2_target_pc  (thread2_target_pc),
		.rs_stall           (rs_stall),
		.rob1_stall         (rob1_stall),
		.rob2_stall         (rob2_stall),
		.rat_stall          (rat_stall),
		.thread1_halt       (thread1_halt),
		.thread2_halt       (thread2_halt),
		.cache              (icache_bus.fetch),
		.inst1_out          (inst1_out),
		.inst2_out          (inst2_out),
		.inst1_valid        (inst1_valid),
		.inst2_valid        (inst2_valid),
		.thread_out         (thread_out)
	);

	icache u_icache (
		.clock     (clock),
		.reset_reg (reset_reg),
		.prdata    (prdata),
		.pready    (pready),
		.fetch     (icache_bus.cache),
		.paddr     (paddr),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite)
	);

endmodule

/* dv/fetch_tb_clock.sv */
`timescale 1ns/10ps

module fetch_tb_clock (
	output logic clock,
	output logic reset_reg
);

	initial
	begin
		clock = 1'b0;
		forever
			#4 clock = ~clock;   // 8 ns period
	end

	initial
	begin
		reset_reg = 1'b1;
		repeat (4) @(posedge clock);   // four reset cycles
		reset_reg <= 1'b0;
	end

endmodule

/* dv/apb_imem_model.sv */
`timescale 1ns/10ps

module apb_imem_model #(
	parameter logic [31:0] MEM_KEY = 32'h0
) (
	input  logic         clock,
	input  logic         reset_reg,
	input  logic [31:0]  paddr,
	input  logic         psel,
	input  logic         penable,
	output logic [31:0]  prdata,
	output logic         pready
);

	integer      seed = 32'hf267_18c4;
	integer      draw;
	logic [1:0]  waits;   // access cycles left before pready

	// read only memory, each word computed from its byte address
	assign prdata = paddr ^ MEM_KEY;
	assign pready = psel && penable && (waits == 2'd0);

	always @(posedge clock)
	begin
		if (reset_reg)
			waits <= 2'd0;
		else if (psel && !penable)
		begin
			draw = $random(seed);   // 0 to 3 wait states per transfer
			waits <= draw[1:0];
		end
		else if (psel && penable && waits != 2'd0)
			waits <= waits - 2'd1;
	end

endmodule

/* dv/fetch_tb.sv */
`timescale 1ns/10ps
`include "fetch_config.svh"

module fetch_tb import fetch_pkg::*; ();

	localparam logic [31:0] MEM_KEY = 32'hc0de_0000;   // word at byte A is A ^ key
	localparam int WAIT_LIMIT = 500;                   // cycles per wait

	logic         clock;
	logic         reset_reg;
	logic         thread1_mispredict;
	logic         thread2_mispredict;
	logic [31:0]  thread1_target_pc;
	logic [31:0]  thread2_target_pc;
	logic         rs_stall;
	logic         rob1_stall;
	logic         rob2_stall;
	logic         rat_stall;
	logic         thread1_halt;
	logic         thread2_halt;
	logic [31:0]  inst1_out;
	logic [31:0]  inst2_out;
	logic         inst1_valid;
	logic         inst2_valid;
	thread_e      thread_out;
	logic [31:0]  paddr;
	logic         psel;
	logic         penable;
	logic         pwrite;
	logic [31:0]  prdata;
	logic         pready;

	// reference model state
	logic [31:0]  exp_pc1;
	logic [31:0]  exp_pc2;
	logic [31:0]  exp_cur;
	logic         t2_halted;
	logic         seen_valid;
	logic         alt_known;   // last_thread is a delivery to alternate from
	thread_e      last_thread;
	logic         any_stall;
	int           errors = 0;
	int           tests_failed = 0;
	int           test_errors = 0;
	string        test_name;

	fetch_tb_clock u_clock (.*);
	apb_imem_model #(.MEM_KEY(MEM_KEY)) u_imem (.*);
	fetch_top u_fetch_top (.*);

	assign any_stall = rs_stall || rob1_stall || rob2_stall || rat_stall;
	assign exp_cur   = (thread_out == THREAD1) ? exp_pc1 : exp_pc2;

	always @(posedge clock)
	begin
		if (reset_reg)
		begin
			exp_pc1     <= `T1_RESET_PC;
			exp_pc2     <= `T2_RESET_PC;
			t2_halted   <= 1'b0;
			seen_valid  <= 1'b0;
			alt_known   <= 1'b0;
			last_thread <= THREAD1;
		end
		else
		begin
			// +4 per delivered instruction
			if (inst1_valid && thread_out == THREAD1)
				exp_pc1 <= exp_pc1 + (inst2_valid ? 32'd8 : 32'd4);
			if (inst1_valid && thread_out == THREAD2)
				exp_pc2 <= exp_pc2 + (inst2_valid ? 32'd8 : 32'd4);
			if (thread1_mispredict)
				exp_pc1 <= thread1_target_pc + 32'd4;
			if (thread2_mispredict)
			begin
				exp_pc2   <= thread2_target_pc + 32'd4;
				t2_halted <= 1'b0;   // mispredict restarts a halted thread
			end
			else if (thread2_halt)
				t2_halted <= 1'b1;
			seen_valid <= seen_valid || inst1_valid;
			if (thread1_mispredict || thread2_mispredict || thread1_halt || thread2_halt
				|| t2_halted)
				alt_known <= 1'b0;
			else if (inst1_valid)
			begin
				alt_known   <= 1'b1;
				last_thread <= thread_out;
			end
		end
	end

	task automatic report_mismatch(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		errors++;
		$display("Mismatch in %s, %s: expected %h, actual %h", test_name, what, expected, actual);
	endtask

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	reset_quiet: assert property (@(posedge clock) reset_reg || $fell(reset_reg)
		|-> !inst1_valid && !psel)
		else report_mismatch("inst1_valid, psel", 0, 32'({$sampled(inst1_valid), $sampled(psel)}));

	first_thread: assert property (@(posedge clock) disable iff (reset_reg)
		inst1_valid && !seen_valid |-> thread_out == THREAD1)
		else report_mismatch("first thread_out", 32'(THREAD1), 32'($sampled(thread_out)));

	inst1_word: assert property (@(posedge clock) disable iff (reset_reg)
		inst1_valid |-> inst1_out == (exp_cur ^ MEM_KEY))
		else report_mismatch("inst1_out", $sampled(exp_cur) ^ MEM_KEY, $sampled(inst1_out));

	inst2_word: assert property (@(posedge clock) disable iff (reset_reg)
		inst2_valid |-> inst2_out == ((exp_cur + 32'd4) ^ MEM_KEY))
		else report_mismatch("inst2_out", ($sampled(exp_cur) + 32'd4) ^ MEM_KEY,
			$sampled(inst2_out));

	// pair only from an 8-byte aligned pc
	pair_by_alignment: assert property (@(posedge clock) disable iff (reset_reg)
		inst1_valid |-> inst2_valid == !exp_cur[2])
		else report_mismatch("inst2_valid", 32'(!$sampled(exp_cur[2])), 32'($sampled(inst2_valid)));

	stall_quiet: assert property (@(posedge clock) disable iff (reset_reg)
		any_stall |-> !inst1_valid && !inst2_valid)
		else report_mismatch("valids in stall", 0,
			32'({$sampled(inst1_valid), $sampled(inst2_valid)}));

	// instruction memory is never written
	read_only: assert property (@(posedge clock) disable iff (reset_reg) !pwrite)
		else report_mismatch("pwrite", 0, 32'($sampled(pwrite)));

	halted_thread: assert property (@(posedge clock) disable iff (reset_reg)
		(t2_halted || thread2_halt) && inst1_valid |-> thread_out == THREAD1)
		else report_mismatch("thread_out while halted", 32'(THREAD1), 32'($sampled(thread_out)));

	alternation: assert property (@(posedge clock) disable iff (reset_reg)
		alt_known && inst1_valid |-> thread_out != last_thread)
		else report_mismatch("thread_out order", 32'(~$sampled(last_thread)),
			32'($sampled(thread_out)));

	//////////////////////////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////////////////////////

	task automatic start_test(input string name);
		test_name   = name;
		test_errors = errors;
	endtask

	task automatic finish_test();
		if (errors == test_errors)
			$display("test %s: ok", test_name);
		else
		begin
			tests_failed++;
			$display("test %s: failed with %0d errors", test_name, errors - test_errors);
		end
	endtask

	task automatic wait_reset_release();
		int cycles = 0;
		while (reset_reg && cycles < WAIT_LIMIT)
		begin
			@(negedge clock);
			cycles++;
		end
		if (reset_reg)
		begin
			errors++;
			$display("timeout: reset_reg was never released");
		end
	endtask

	// deliveries of one thread, sampled mid cycle
	task automatic wait_deliveries(input thread_e which, input int count);
		int seen = 0;
		int cycles = 0;
		while (seen < count && cycles < WAIT_LIMIT)
		begin
			@(negedge clock);
			cycles++;
			if (inst1_valid && thread_out == which)
				seen++;
		end
		if (seen < count)
		begin
			errors++;
			$display("timeout: %s got only %0d of %0d deliveries from %s", test_name, seen,
				count, which.name());
		end
	endtask

	task automatic redirect(input thread_e which, input logic [31:0] target);
		@(posedge clock);
		if (which == THREAD1)
		begin
			thread1_mispredict <= 1'b1;
			thread1_target_pc  <= target;
		end
		else
		begin
			thread2_mispredict <= 1'b1;
			thread2_target_pc  <= target;
		end
		@(posedge clock);
		thread1_mispredict <= 1'b0;
		thread2_mispredict <= 1'b0;
	endtask

	task automatic pulse_stall(input int which, input int cycles);
		@(posedge clock);
		case (which)
			0: rs_stall <= 1'b1;
			1: rob1_stall <= 1'b1;
			2: rob2_stall <= 1'b1;
			default: rat_stall <= 1'b1;
		endcase
		repeat (cycles) @(posedge clock);
		rs_stall   <= 1'b0;
		rob1_stall <= 1'b0;
		rob2_stall <= 1'b0;
		rat_stall  <= 1'b0;
	endtask

	initial
	begin
		start_test("reset");
		thread1_mispredict <= 1'b0;
		thread2_mispredict <= 1'b0;
		thread1_target_pc  <= '0;
		thread2_target_pc  <= '0;
		rs_stall           <= 1'b0;
		rob1_stall         <= 1'b0;
		rob2_stall         <= 1'b0;
		rat_stall          <= 1'b0;
		thread1_halt       <= 1'b0;
		thread2_halt       <= 1'b0;
		wait_reset_release();
		wait_deliveries(THREAD1, 1);
		finish_test();

		start_test("sequential");
		wait_deliveries(THREAD1, 8);
		wait_deliveries(THREAD2, 8);
		finish_test();

		start_test("stall");
		for (int i = 0; i < 4; i++)
			pulse_stall(i, 3 + i);
		wait_deliveries(THREAD1, 4);
		wait_deliveries(THREAD2, 4);
		finish_test();

		start_test("mispredict");
		redirect(THREAD2, 32'h0000_3000);
		wait_deliveries(THREAD2, 3);   // single word, then pairs
		finish_test();

		start_test("halt");
		@(posedge clock);
		thread2_halt <= 1'b1;
		@(posedge clock);
		thread2_halt <= 1'b0;
		wait_deliveries(THREAD1, 6);
		redirect(THREAD2, 32'h0000_2400);
		wait_deliveries(THREAD2, 3);
		wait_deliveries(THREAD1, 2);
		finish_test();

		repeat (4) @(posedge clock);
		$display("tests 5, failed %0d, errors %0d", tests_failed, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

/* src.f */
+incdir+source
source/fetch_pkg.sv
source/icache_if.sv
source/fetch_stage.sv
source/icache.sv
source/fetch_top.sv
dv/fetch_tb_clock.sv
dv/apb_imem_model.sv
dv/fetch_tb.sv

/* run.sh */
#!/bin/sh
# build the fetch testbench with verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f src.f --top-module fetch_tb -o fetch_sim
output=$(./obj_dir/fetch_sim)
echo "$output"
if echo "$output" | grep -q "Simulation PASSED"
then
	exit 0
fi
exit 1
